// ==== proc.f ====
procPkg.sv
regFile.sv
pipeLatch.sv
decodeInstruction.sv
executeInstruction.sv
writebackResult.sv
proc.sv
proc_assertions.sv
proc_tb.sv

// ==== proc_tb.sv ====
// ========================================
// self-checking testbench for the core
// drives a table of directed and LFSR
// instructions and compares every result
// with a reference register model
// ========================================
`default_nettype none

module proc_tb;

  import procPkg::*;

  localparam int maxTests    = 128;
  localparam int randomCount = 40;

  logic        clk = 1'b0;
  logic        rstN;
  logic [15:0] instr;
  logic        instrValid;
  logic        resultValid;
  logic [2:0]  resultReg;
  logic [15:0] resultData;
  logic        err;

  // stimulus and expected values per row
  string       testName  [maxTests];
  logic [15:0] testInstr [maxTests];
  logic        testValid [maxTests];
  logic        expValid  [maxTests];
  logic [2:0]  expReg    [maxTests];
  logic [15:0] expData   [maxTests];
  logic        expErr    [maxTests];
  int          testCount;
  int          tableLen;
  logic        tableReady = 1'b0;

  logic [15:0] modelRegs [8];
  logic        modelErr;
  logic [15:0] lfsrState;
  int          passCount = 0;
  int          failCount = 0;

  proc dut (
    .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid),
    .resultValid(resultValid), .resultReg(resultReg),
    .resultData(resultData), .err(err)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] rInstr(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [2:0] rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  function automatic logic [15:0] iInstr(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [5:0] imm6);
    return {op, rd, rs, imm6};
  endfunction

  function automatic logic [15:0] lbiInstr(input logic [2:0] rd, input logic [8:0] imm9);
    return {LBI, rd, imm9};
  endfunction

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;  // galois taps 16,14,13,11
    end
    return s >> 1;
  endfunction

  task automatic takeBits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[14:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // reference model applied in program order
  task automatic addTest(input string name, input logic [15:0] word, input logic valid);
    logic [15:0] rsVal;
    logic [15:0] rtVal;
    logic [15:0] value;
    logic        writes;
    rsVal  = modelRegs[word[8:6]];
    rtVal  = modelRegs[word[5:3]];
    value  = '0;
    writes = valid;
    if (valid) begin
      case (word[15:12])
        ADD:   value = rsVal + rtVal;
        SUB:   value = rsVal - rtVal;
        AND:   value = rsVal & rtVal;
        XOR:   value = rsVal ^ rtVal;
        SLL:   value = rsVal << rtVal[3:0];
        SRL:   value = rsVal >> rtVal[3:0];
        SLT:   value = ($signed(rsVal) < $signed(rtVal)) ? 16'd1 : 16'd0;
        ADDI:  value = rsVal + {{10{word[5]}}, word[5:0]};
        ANDNI: value = rsVal & ~{10'b0, word[5:0]};
        LBI:   value = {{7{word[8]}}, word[8:0]};
        NOP:   writes = 1'b0;
        default: begin
          writes   = 1'b0;
          modelErr = 1'b1;
        end
      endcase
    end
    if (writes) begin
      modelRegs[word[11:9]] = value;
    end
    testName[testCount]  = name;
    testInstr[testCount] = word;
    testValid[testCount] = valid;
    expValid[testCount]  = writes;
    expReg[testCount]    = word[11:9];
    expData[testCount]   = value;
    expErr[testCount]    = modelErr;
    testCount++;
  endtask

  task automatic buildTable();
    logic [15:0] bits;
    logic [3:0]  op;
    for (int r = 0; r < 8; r++) begin
      modelRegs[r] = '0;
    end
    modelErr  = 1'b0;
    testCount = 0;
    for (int r = 0; r < 8; r++) begin
      addTest($sformatf("zero r%0d", r), iInstr(ADDI, 3'(r), 3'(r), 6'd0), 1'b1);
    end
    addTest("lbi pos", lbiInstr(3'd1, 9'h0A5), 1'b1);
    addTest("lbi neg", lbiInstr(3'd2, 9'h1F3), 1'b1);
    addTest("bubble", 16'h0000, 1'b0);
    addTest("nop", rInstr(NOP, 3'd3, 3'd1, 3'd2), 1'b1);
    addTest("add", rInstr(ADD, 3'd3, 3'd1, 3'd2), 1'b1);
    addTest("sub", rInstr(SUB, 3'd4, 3'd1, 3'd2), 1'b1);
    addTest("and", rInstr(AND, 3'd5, 3'd1, 3'd2), 1'b1);
    addTest("xor", rInstr(XOR, 3'd6, 3'd1, 3'd2), 1'b1);
    addTest("lbi shamt", lbiInstr(3'd7, 9'd3), 1'b1);
    addTest("sll", rInstr(SLL, 3'd3, 3'd1, 3'd7), 1'b1);
    addTest("srl", rInstr(SRL, 3'd4, 3'd2, 3'd7), 1'b1);
    addTest("slt true", rInstr(SLT, 3'd5, 3'd2, 3'd1), 1'b1);
    addTest("slt false", rInstr(SLT, 3'd6, 3'd1, 3'd2), 1'b1);
    addTest("addi neg", iInstr(ADDI, 3'd3, 3'd1, 6'h3F), 1'b1);
    addTest("andni", iInstr(ANDNI, 3'd4, 3'd2, 6'h2F), 1'b1);  // imm bit 5 set
    // back to back dependencies served by forwarding
    addTest("fwd base", lbiInstr(3'd1, 9'd5), 1'b1);
    addTest("fwd rs", iInstr(ADDI, 3'd1, 3'd1, 6'd9), 1'b1);  // imm rt field names r1
    addTest("fwd rt", rInstr(ADD, 3'd2, 3'd0, 3'd1), 1'b1);
    addTest("fwd both", rInstr(ADD, 3'd2, 3'd2, 3'd2), 1'b1);
    addTest("dist base", lbiInstr(3'd3, 9'd7), 1'b1);
    addTest("dist fill", lbiInstr(3'd6, 9'd1), 1'b1);
    addTest("dist two", rInstr(ADD, 3'd4, 3'd3, 3'd3), 1'b1);  // regFile bypass
    addTest("dist three", rInstr(SUB, 3'd5, 3'd3, 3'd6), 1'b1);
    addTest("illegal", 16'hB123, 1'b1);
    addTest("after err", lbiInstr(3'd7, 9'h100), 1'b1);
    addTest("after err fwd", iInstr(ADDI, 3'd7, 3'd7, 6'd2), 1'b1);
    addTest("after err bubble", 16'hFFFF, 1'b0);
    tableLen = testCount;
    for (int n = 0; n < randomCount; n++) begin
      takeBits(4, bits);
      op = bits[3:0] % 4'd11;  // legal codes only
      takeBits(12, bits);
      addTest($sformatf("random %0d", n), {op, bits[11:0]}, 1'b1);
    end
  endtask

  task automatic checkEntry(input int e);
    if (resultValid !== expValid[e]) begin
      $display("** Error %s: resultValid expected %b actual %b",
               testName[e], expValid[e], resultValid);
      failCount++;
    end else if (expValid[e] && resultReg !== expReg[e]) begin
      $display("** Error %s: resultReg expected %0d actual %0d",
               testName[e], expReg[e], resultReg);
      failCount++;
    end else if (expValid[e] && resultData !== expData[e]) begin
      $display("** Error %s: resultData expected %h actual %h",
               testName[e], expData[e], resultData);
      failCount++;
    end else if (err !== expErr[e]) begin
      $display("** Error %s: err expected %b actual %b", testName[e], expErr[e], err);
      failCount++;
    end else begin
      $display("ok    %s", testName[e]);
      passCount++;
    end
  endtask

  initial begin
    rstN       = 1'b0;
    instr      = '0;
    instrValid = 1'b0;
    lfsrState  = 16'd90;
    buildTable();
    tableReady = 1'b1;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    if (resultValid !== 1'b0 || err !== 1'b0) begin
      $display("** Error reset: resultValid,err expected 00 actual %b%b", resultValid, err);
      failCount++;
    end else begin
      $display("ok    reset");
      passCount++;
    end
    // issue row c and check row c-2 at the ports
    for (int c = 0; c < testCount + 2; c++) begin
      @(posedge clk);
      if (c < testCount) begin
        instr      <= testInstr[c];
        instrValid <= testValid[c];
      end else begin
        instr      <= '0;
        instrValid <= 1'b0;
      end
      @(negedge clk);
      if (c >= 2) begin
        checkEntry(c - 2);
      end
    end
    $display("%0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (tableReady);
    #((tableLen + randomCount + 20) * 10);
    $display("timeout: the run did not finish within its cycle budget");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== proc_assertions.sv ====
// ========================================
// concurrent checks on the core outputs,
// bound into the top level
// ========================================
`default_nettype none

module procAssertions (
  input logic clk,
  input logic rstN,
  input logic resultValid,
  input logic err
);

  // latches and error flag are cleared by reset
  property quietAfterReset;
    @(posedge clk) !rstN |=> (!resultValid && !err);
  endproperty

  property errSticky;
    @(posedge clk) disable iff (!rstN) err |=> err;
  endproperty

  property validKnown;
    @(posedge clk) disable iff (!rstN) !$isunknown(resultValid);
  endproperty

  quietCheck: assert property (quietAfterReset)
    else $error("resultValid or err high in the cycle after reset");
  stickyCheck: assert property (errSticky)
    else $error("err fell while out of reset");
  knownCheck: assert property (validKnown)
    else $error("resultValid is unknown");

endmodule

bind proc procAssertions outputChecks (
  .clk(clk), .rstN(rstN), .resultValid(resultValid), .err(err)
);

`default_nettype wire

// ==== proc.sv ====
// ======================================
// top of the three-stage core: decode,
// execute and result stage with a latch
// between each; one instruction per cycle
// ======================================
`default_nettype none

module proc (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [procPkg::wordWidth-1:0]    instr,
  input  logic                             instrValid,
  output logic                             resultValid,
  output logic [procPkg::regAddrWidth-1:0] resultReg,
  output logic [procPkg::wordWidth-1:0]    resultData,
  output logic                             err
);

  import procPkg::*;

  logic [regAddrWidth-1:0] readAddrA;
  logic [regAddrWidth-1:0] readAddrB;
  logic [wordWidth-1:0]    readDataA;
  logic [wordWidth-1:0]    readDataB;

  decoded_t  idDecoded;   // decode output
  decoded_t  exDecoded;   // latched into execute
  logic      exValid;
  result_t   exResult;    // execute output
  result_t   wbResult;    // latched into result stage
  logic      wbValid;
  regWrite_t wbWrite;     // write port, also forwarded

  regFile registers (
    .clk(clk), .rstN(rstN),
    .readAddrA(readAddrA), .readAddrB(readAddrB),
    .readDataA(readDataA), .readDataB(readDataB),
    .write(wbWrite)
  );

  decodeInstruction instructionDecode (
    .instr(instr),
    .readAddrA(readAddrA), .readAddrB(readAddrB),
    .readDataA(readDataA), .readDataB(readDataB),
    .decoded(idDecoded)
  );

  pipeLatch #(.payload_t(decoded_t)) idExStage (
    .clk(clk), .rstN(rstN),
    .validIn(instrValid), .dataIn(idDecoded),
    .validOut(exValid), .dataOut(exDecoded)
  );

  executeInstruction instructionExecute (
    .decoded(exDecoded), .fwd(wbWrite), .result(exResult)
  );

  pipeLatch #(.payload_t(result_t)) exWbStage (
    .clk(clk), .rstN(rstN),
    .validIn(exValid), .dataIn(exResult),
    .validOut(wbValid), .dataOut(wbResult)
  );

  writebackResult instructionWriteback (
    .clk(clk), .rstN(rstN),
    .valid(wbValid), .result(wbResult), .write(wbWrite),
    .resultValid(resultValid), .resultReg(resultReg),
    .resultData(resultData), .err(err)
  );

endmodule

`default_nettype wire

// ==== writebackResult.sv ====
// ======================================
// result stage: drives the register-file
// write port, the result ports and the
// sticky error flag
// ======================================
`default_nettype none

module writebackResult (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             valid,
  input  procPkg::result_t                 result,
  output procPkg::regWrite_t               write,
  output logic                             resultValid,
  output logic [procPkg::regAddrWidth-1:0] resultReg,
  output logic [procPkg::wordWidth-1:0]    resultData,
  output logic                             err
);

  logic errSeen;  // an illegal opcode has retired
  logic errNow;

  assign write.en   = valid && result.regWrite;
  assign write.addr = result.rd;
  assign write.data = result.value;

  // ports mirror the write port
  assign resultValid = write.en;
  assign resultReg   = write.addr;
  assign resultData  = write.data;

  assign errNow = valid && result.illegal;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      errSeen <= 1'b0;
    end else if (errNow) begin
      errSeen <= 1'b1;
    end
  end

  assign err = errSeen || errNow;  // rises with the offending slot

endmodule

`default_nettype wire

// ==== executeInstruction.sv ====
// ======================================
// execute stage: forwards the result of
// the previous instruction into stale
// operands, then runs the ALU
// ======================================
`default_nettype none

module executeInstruction (
  input  procPkg::decoded_t  decoded,
  input  procPkg::regWrite_t fwd,
  output procPkg::result_t   result
);

  import procPkg::*;

  logic                 fwdA;
  logic                 fwdB;
  logic [wordWidth-1:0] a;
  logic [wordWidth-1:0] b;
  logic [3:0]           shamt;
  logic                 less;

  // operands were read a cycle ago, the instruction now in the
  // result stage may have overwritten them
  assign fwdA = fwd.en && (fwd.addr == decoded.rsNum);
  assign fwdB = fwd.en && !decoded.useImm && (fwd.addr == decoded.rtNum);

  assign a = fwdA ? fwd.data : decoded.opA;
  assign b = fwdB ? fwd.data : decoded.opB;

  assign shamt = b[3:0];
  assign less  = $signed(a) < $signed(b);

  always_comb begin
    result.rd       = decoded.rd;
    result.regWrite = decoded.regWrite;
    result.illegal  = decoded.illegal;
    case (decoded.op)
      ADD:     result.value = a + b;
      SUB:     result.value = a - b;
      AND:     result.value = a & b;
      XOR:     result.value = a ^ b;
      SLL:     result.value = a << shamt;
      SRL:     result.value = a >> shamt;  // logical
      SLT:     result.value = {{(wordWidth - 1){1'b0}}, less};
      ADDI:    result.value = a + b;
      ANDNI:   result.value = a & ~b;
      LBI:     result.value = b;           // immediate only
      default: result.value = '0;          // NOP and illegal codes
    endcase
  end

endmodule

`default_nettype wire

// ==== decodeInstruction.sv ====
// ======================================
// decode stage: splits the instruction,
// extends immediates, reads operands and
// flags illegal opcodes; combinational
// ======================================
`default_nettype none

module decodeInstruction (
  input  logic [procPkg::wordWidth-1:0]    instr,
  output logic [procPkg::regAddrWidth-1:0] readAddrA,
  output logic [procPkg::regAddrWidth-1:0] readAddrB,
  input  logic [procPkg::wordWidth-1:0]    readDataA,
  input  logic [procPkg::wordWidth-1:0]    readDataB,
  output procPkg::decoded_t                decoded
);

  import procPkg::*;

  opcode_t                 op;
  logic [regAddrWidth-1:0] rd;
  logic [imm6Width-1:0]    imm6;
  logic [imm9Width-1:0]    imm9;
  logic [wordWidth-1:0]    immExt;
  logic                    useImm;
  logic                    regWrite;
  logic                    illegal;

  // field split
  assign op        = opcode_t'(instr[15:12]);
  assign rd        = instr[11:9];
  assign readAddrA = instr[8:6];   // rs
  assign readAddrB = instr[5:3];   // rt
  assign imm6      = instr[imm6Width-1:0];
  assign imm9      = instr[imm9Width-1:0];

  // control and immediate selection per opcode
  always_comb begin
    immExt   = '0;
    useImm   = 1'b0;
    regWrite = 1'b1;
    illegal  = 1'b0;
    case (op)
      ADD, SUB, AND, XOR, SLL, SRL, SLT: begin
        useImm = 1'b0;  // both operands from registers
      end
      ADDI: begin
        useImm = 1'b1;
        immExt = {{(wordWidth - imm6Width){imm6[imm6Width-1]}}, imm6};
      end
      ANDNI: begin
        useImm = 1'b1;
        immExt = {{(wordWidth - imm6Width){1'b0}}, imm6};  // inverted in the ALU
      end
      LBI: begin
        useImm = 1'b1;
        immExt = {{(wordWidth - imm9Width){imm9[imm9Width-1]}}, imm9};
      end
      NOP: begin
        regWrite = 1'b0;
      end
      default: begin
        // unused code, never writes
        regWrite = 1'b0;
        illegal  = 1'b1;
      end
    endcase
  end

  always_comb begin
    decoded.op       = op;
    decoded.rd       = rd;
    decoded.rsNum    = readAddrA;
    decoded.rtNum    = readAddrB;
    decoded.opA      = readDataA;
    decoded.opB      = useImm ? immExt : readDataB;
    decoded.useImm   = useImm;
    decoded.regWrite = regWrite;
    decoded.illegal  = illegal;
  end

endmodule

`default_nettype wire

// ==== pipeLatch.sv ====
// ======================================
// stage register for any payload type
// payload loads every cycle, valid bit
// is the only state cleared by reset
// ======================================
`default_nettype none

module pipeLatch #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     validIn,
  input  payload_t dataIn,
  output logic     validOut,
  output payload_t dataOut
);

  // valid marks a real instruction, low is a bubble
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validOut <= 1'b0;
    end else begin
      validOut <= validIn;
    end
  end

  always_ff @(posedge clk) begin
    dataOut <= dataIn;  // no stall, so no enable
  end

endmodule

`default_nettype wire

// ==== regFile.sv ====
// ======================================
// eight 16-bit registers, two read ports
// and one write port; a read of the
// register being written sees new data
// ======================================
`default_nettype none

module regFile (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [procPkg::regAddrWidth-1:0] readAddrA,
  input  logic [procPkg::regAddrWidth-1:0] readAddrB,
  output logic [procPkg::wordWidth-1:0]    readDataA,
  output logic [procPkg::wordWidth-1:0]    readDataB,
  input  procPkg::regWrite_t               write
);

  import procPkg::*;

  logic [wordWidth-1:0] regs [regCount];
  logic                 hitA;
  logic                 hitB;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (write.en) begin
      regs[write.addr] <= write.data;
    end
  end

  // write-to-read bypass, covers a dependency at distance two
  assign hitA = write.en && (write.addr == readAddrA);
  assign hitB = write.en && (write.addr == readAddrB);

  assign readDataA = hitA ? write.data : regs[readAddrA];
  assign readDataB = hitB ? write.data : regs[readAddrB];

endmodule

`default_nettype wire

// ==== procPkg.sv ====
// ======================================
// shared definitions for the 16-bit core
// opcodes, field widths and the payload
// structs passed between pipeline stages
// ======================================
`default_nettype none

package procPkg;

  localparam int wordWidth    = 16;  // operand and instruction width
  localparam int regAddrWidth = 3;
  localparam int regCount     = 1 << regAddrWidth;
  localparam int opWidth      = 4;
  localparam int imm6Width    = 6;
  localparam int imm9Width    = 9;

  // codes 11 to 15 are illegal
  typedef enum logic [opWidth-1:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,   // rs minus rt
    AND   = 4'd2,
    XOR   = 4'd3,
    SLL   = 4'd4,   // shift amount from low four bits of rt
    SRL   = 4'd5,
    SLT   = 4'd6,   // signed, result 1 or 0
    ADDI  = 4'd7,   // rs + sext(imm6)
    ANDNI = 4'd8,   // rs & ~zext(imm6)
    LBI   = 4'd9,   // sext(imm9)
    NOP   = 4'd10
  } opcode_t;

  // instruction layout
  //   [15:12] opcode  [11:9] rd  [8:6] rs  [5:3] rt
  //   [5:0] imm6      [8:0] imm9

  // decode to execute
  typedef struct packed {
    opcode_t                 op;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rsNum;
    logic [regAddrWidth-1:0] rtNum;
    logic [wordWidth-1:0]    opA;
    logic [wordWidth-1:0]    opB;       // register value or extended immediate
    logic                    useImm;
    logic                    regWrite;
    logic                    illegal;
  } decoded_t;

  // execute to result stage
  typedef struct packed {
    logic [regAddrWidth-1:0] rd;
    logic [wordWidth-1:0]    value;
    logic                    regWrite;
    logic                    illegal;
  } result_t;

  // register-file write port, also seen by execute for forwarding
  typedef struct packed {
    logic                    en;
    logic [regAddrWidth-1:0] addr;
    logic [wordWidth-1:0]    data;
  } regWrite_t;

endpackage

`default_nettype wire
